// ==== hdl/bt656_pkg.sv ====
/* BT.656 stream definitions: timing reference preamble,
   code byte layout and the protection nibble table. */

package bt656_pkg;

	// **********************************************************
	// timing reference preamble
	// **********************************************************

	localparam logic [7:0] preamble_ff = 8'hff; // first preamble byte.
	localparam logic [7:0] preamble_00 = 8'h00; // second and third preamble bytes.

	// **********************************************************
	// code byte XY, laid out as 1 F V H P3 P2 P1 P0
	// **********************************************************

	localparam int xy_bit_one = 7; // always set in a legal code byte.
	localparam int xy_bit_f   = 6; // field, 0 for field 1 and 1 for field 2.
	localparam int xy_bit_v   = 5; // set during vertical blanking.
	localparam int xy_bit_h   = 4; // 0 at start of active video, 1 at its end.

	// Protection nibbles for every F V H combination, index {F, V, H}.
	// P3 = V^H, P2 = F^H, P1 = F^V, P0 = F^V^H.
	localparam logic [7:0][3:0] xy_prot_table = {
		4'h1, // F V H = 111.
		4'hc, // 110.
		4'ha, // 101.
		4'h7, // 100.
		4'h6, // 011.
		4'hb, // 010.
		4'hd, // 001.
		4'h0  // 000.
	};

endpackage

// ==== hdl/bt656cap_colorspace.sv ====
/* YCbCr 4:2:2 to RGB565 converter with one shared multiplier,
   a five-state sequence and saturation to 0..255. */

`timescale 1ns/1ps

module bt656cap_colorspace (
	input  logic               vid_clk,
	input  logic               rst_n_i,
	input  logic               stb_i,
	input  pix_pkg::vid_tag_t  tag_i,
	input  pix_pkg::ycc_word_t ycc_i,
	output logic               stb_o,
	output pix_pkg::vid_tag_t  tag_o,
	output pix_pkg::rgb_pair_t rgb_o
);

	typedef enum logic [2:0] {
		s_idle,
		s_red,
		s_blue,
		s_green,
		s_out
	} state_t;

	state_t state;
	state_t state_nxt;

	logic signed [7:0]  cb_s;
	logic signed [7:0]  y0_s;
	logic signed [7:0]  cr_s;
	logic signed [7:0]  y1_s;

	logic               sel_cr;   // multiply Cr instead of Cb.
	logic [1:0]         sel_coef;
	logic signed [7:0]  mult_a;
	logic signed [9:0]  mult_b;
	logic signed [17:0] mult_q;
	logic signed [9:0]  term;

	logic               load_y;
	logic               add_r;
	logic               add_b;
	logic               sub_g;
	logic               out_en;

	logic signed [9:0]  r0_q, g0_q, b0_q;
	logic signed [9:0]  r1_q, g1_q, b1_q;
	logic signed [9:0]  g0_fin;
	logic signed [9:0]  g1_fin;
	pix_pkg::vid_tag_t  tag_q;

	// negative clamps to 0, above 255 clamps to 255.
	function automatic logic [7:0] sat8(input logic signed [9:0] v);
		logic [7:0] res;
		res = v[7:0] | {8{v[8]}};
		return res & {8{~v[9]}};
	endfunction

	function automatic pix_pkg::rgb565_t to565(
		input logic signed [9:0] r,
		input logic signed [9:0] g,
		input logic signed [9:0] b
	);
		logic [7:0] r8;
		logic [7:0] g8;
		logic [7:0] b8;
		r8 = sat8(r);
		g8 = sat8(g);
		b8 = sat8(b);
		return '{r: r8[7:3], g: g8[7:2], b: b8[7:3]};
	endfunction

	// **********************************************************
	// datapath
	// **********************************************************

	assign cb_s = ycc_i.cb - 8'd128;
	assign y0_s = ycc_i.y0 - 8'd128;
	assign cr_s = ycc_i.cr - 8'd128;
	assign y1_s = ycc_i.y1 - 8'd128;

	assign mult_a = sel_cr ? cr_s : cb_s;

	always_comb begin
		case (sel_coef)
			2'd0: mult_b = pix_pkg::coef_cr_r;
			2'd1: mult_b = pix_pkg::coef_cb_b;
			2'd2: mult_b = pix_pkg::coef_cb_g;
			default: mult_b = pix_pkg::coef_cr_g;
		endcase
	end

	always_ff @(posedge vid_clk) begin
		mult_q <= mult_a * mult_b;
	end

	assign term = mult_q[17:8]; // drop the 8 fraction bits.

	always_ff @(posedge vid_clk) begin
		if (load_y) begin
			r0_q <= y0_s;
			g0_q <= y0_s;
			b0_q <= y0_s;
			r1_q <= y1_s;
			g1_q <= y1_s;
			b1_q <= y1_s;
		end
		if (add_r) begin
			r0_q <= r0_q + term;
			r1_q <= r1_q + term;
		end
		if (add_b) begin
			b0_q <= b0_q + term;
			b1_q <= b1_q + term;
		end
		if (sub_g) begin
			g0_q <= g0_q - term;
			g1_q <= g1_q - term;
		end
	end

	// The Cr term of green is still in the multiplier output.
	assign g0_fin = g0_q - term;
	assign g1_fin = g1_q - term;

	always_ff @(posedge vid_clk) begin
		if (stb_i) begin
			tag_q <= tag_i;
		end
		if (out_en) begin
			tag_o    <= tag_q;
			rgb_o.p0 <= to565(r0_q, g0_fin, b0_q);
			rgb_o.p1 <= to565(r1_q, g1_fin, b1_q);
		end
	end

	// **********************************************************
	// controller
	// **********************************************************

	always_ff @(posedge vid_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= s_idle;
			stb_o <= 1'b0;
		end else begin
			state <= state_nxt;
			stb_o <= out_en;
		end
	end

	always_comb begin
		sel_cr    = 1'b1;
		sel_coef  = 2'd0;
		load_y    = 1'b0;
		add_r     = 1'b0;
		add_b     = 1'b0;
		sub_g     = 1'b0;
		out_en    = 1'b0;
		state_nxt = state;
		case (state)
			s_idle: begin
				load_y = 1'b1;                   // Cr * 1.402 runs meanwhile.
				if (stb_i) state_nxt = s_red;
			end
			s_red: begin
				add_r     = 1'b1;
				sel_cr    = 1'b0;
				sel_coef  = 2'd1;                // Cb * 1.772.
				state_nxt = s_blue;
			end
			s_blue: begin
				add_b     = 1'b1;
				sel_cr    = 1'b0;
				sel_coef  = 2'd2;                // Cb * 0.344.
				state_nxt = s_green;
			end
			s_green: begin
				sub_g     = 1'b1;
				sel_coef  = 2'd3;                // Cr * 0.714.
				state_nxt = s_out;
			end
			s_out: begin
				out_en    = 1'b1;
				load_y    = 1'b1;                // a following word starts here.
				state_nxt = stb_i ? s_red : s_idle;
			end
			default: state_nxt = s_idle;
		endcase
	end

	// Relies on the decoder spacing its words.
	a_no_stb_busy: assert property (@(posedge vid_clk) disable iff (!rst_n_i)
		(state inside {s_red, s_blue, s_green}) |-> !stb_i);

endmodule

// ==== hdl/bt656cap_decoder.sv ====
/* BT.656 decoder: finds timing reference codes, tracks field and
   active video, and packs Cb Y0 Cr Y1 bytes into tagged words. */

`timescale 1ns/1ps

module bt656cap_decoder (
	input  logic               vid_clk,
	input  logic               rst_n_i,
	input  logic [7:0]         vid_data_i,
	output logic               word_stb_o,
	output pix_pkg::ycc_word_t word_o,
	output pix_pkg::vid_tag_t  tag_o
);

	logic [3:0][7:0] hist;   // byte history, hist[0] is the newest.
	logic [7:0]      xy;
	logic [2:0]      fvh;
	logic            pre_ok;
	logic            code_ok;
	logic            code_sav;
	logic            emit;

	logic            active; // inside active video.
	logic            field_q;
	logic            sol_pend;
	logic [1:0]      phase;  // position of hist[0] within the quadruple.

	logic [7:0]      cb_q;
	logic [7:0]      y0_q;
	logic [7:0]      cr_q;

	// **********************************************************
	// timing reference detection
	// **********************************************************

	assign xy = hist[0];
	assign fvh = {xy[bt656_pkg::xy_bit_f], xy[bt656_pkg::xy_bit_v], xy[bt656_pkg::xy_bit_h]};

	assign pre_ok = (hist[3] == bt656_pkg::preamble_ff) &&
		(hist[2] == bt656_pkg::preamble_00) &&
		(hist[1] == bt656_pkg::preamble_00);

	// Inside active video a code can only end on a quadruple boundary.
	assign code_ok = pre_ok && xy[bt656_pkg::xy_bit_one] &&
		(xy[3:0] == bt656_pkg::xy_prot_table[fvh]) &&
		(!active || (phase == 2'd3));

	// start of active video outside vertical blanking.
	assign code_sav = !xy[bt656_pkg::xy_bit_h] && !xy[bt656_pkg::xy_bit_v];

	// The preamble bytes of an end code never leave as a word.
	assign emit = active && (phase == 2'd3) && !pre_ok;

	// **********************************************************
	// control
	// **********************************************************

	always_ff @(posedge vid_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hist       <= '0;
			active     <= 1'b0;
			field_q    <= 1'b0;
			sol_pend   <= 1'b0;
			phase      <= 2'd0;
			word_stb_o <= 1'b0;
		end else begin
			hist       <= {hist[2:0], vid_data_i};
			word_stb_o <= emit;
			phase      <= phase + 2'd1;
			if (code_ok) begin
				active <= code_sav;        // any other code closes the line.
				phase  <= 2'd0;            // the next byte is Cb.
				if (code_sav) begin
					field_q  <= xy[bt656_pkg::xy_bit_f];
					sol_pend <= 1'b1;
				end
			end else if (emit) begin
				sol_pend <= 1'b0;
			end
		end
	end

	// **********************************************************
	// word assembly
	// **********************************************************

	always_ff @(posedge vid_clk) begin
		if (active) begin
			case (phase)
				2'd0: cb_q <= hist[0];
				2'd1: y0_q <= hist[0];
				2'd2: cr_q <= hist[0];
				default: ;                 // Y1 goes straight into the word.
			endcase
		end
		if (emit) begin
			word_o <= '{cb: cb_q, y0: y0_q, cr: cr_q, y1: hist[0]};
			tag_o  <= '{field: field_q, sol: sol_pend};
		end
	end

	// The converter needs four cycles per word.
	a_word_spacing: assert property (@(posedge vid_clk) disable iff (!rst_n_i)
		word_stb_o |=> !word_stb_o [*3]);

endmodule

// ==== hdl/bt656cap_raster.sv ====
/* Raster stage: tags each RGB565 pair with its column and line. */

`timescale 1ns/1ps

module bt656cap_raster (
	input  logic               vid_clk,
	input  logic               rst_n_i,
	input  logic               stb_i,
	input  pix_pkg::vid_tag_t  tag_i,
	input  pix_pkg::rgb_pair_t rgb_i,
	output logic               pix_stb_o,
	output pix_pkg::pix_out_t  pix_o
);

	logic [pix_pkg::x_width-1:0] x_q;
	logic [pix_pkg::x_width-1:0] x_nxt;
	logic [pix_pkg::y_width-1:0] y_q;
	logic [pix_pkg::y_width-1:0] y_nxt;
	logic                        fld_q;  // field of the last line.
	logic                        seen_q; // a line has started since reset.
	logic                        new_field;

	assign new_field = !seen_q || (tag_i.field != fld_q);

	always_comb begin
		x_nxt = x_q + 1'b1;
		y_nxt = y_q;
		if (tag_i.sol) begin
			x_nxt = '0;
			y_nxt = new_field ? '0 : y_q + 1'b1;
		end
	end

	always_ff @(posedge vid_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			x_q       <= '0;
			y_q       <= '0;
			fld_q     <= 1'b0;
			seen_q    <= 1'b0;
			pix_stb_o <= 1'b0;
		end else begin
			pix_stb_o <= stb_i;
			if (stb_i) begin
				x_q <= x_nxt;
				y_q <= y_nxt;
				if (tag_i.sol) begin
					fld_q  <= tag_i.field;
					seen_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge vid_clk) begin
		if (stb_i) begin
			pix_o <= '{field: tag_i.field, x: x_nxt, y: y_nxt, pair: rgb_i};
		end
	end

	// Only the first pair of a line may sit at column 0.
	a_x_no_wrap: assert property (@(posedge vid_clk) disable iff (!rst_n_i)
		(stb_i && !tag_i.sol) |=> (pix_o.x != '0));

endmodule

// ==== hdl/bt656cap_top.sv ====
/* BT.656 capture core: decoder, colorspace converter and raster
   stage in a chain, from the byte stream to addressed RGB565 pairs. */

`timescale 1ns/1ps

module bt656cap_top (
	input  logic              vid_clk,
	input  logic              rst_n_i,
	input  logic [7:0]        vid_data_i,
	output logic              pix_stb_o,
	output pix_pkg::pix_out_t pix_o
);

	logic               word_stb;
	pix_pkg::ycc_word_t word;
	pix_pkg::vid_tag_t  tag;

	logic               rgb_stb;
	pix_pkg::rgb_pair_t rgb;
	pix_pkg::vid_tag_t  rgb_tag;

	bt656cap_decoder u_decoder (
		.vid_clk    (vid_clk),
		.rst_n_i    (rst_n_i),
		.vid_data_i (vid_data_i),
		.word_stb_o (word_stb),
		.word_o     (word),
		.tag_o      (tag)
	);

	bt656cap_colorspace u_colorspace (
		.vid_clk (vid_clk),
		.rst_n_i (rst_n_i),
		.stb_i   (word_stb),
		.tag_i   (tag),
		.ycc_i   (word),
		.stb_o   (rgb_stb),
		.tag_o   (rgb_tag),
		.rgb_o   (rgb)
	);

	bt656cap_raster u_raster (
		.vid_clk   (vid_clk),
		.rst_n_i   (rst_n_i),
		.stb_i     (rgb_stb),
		.tag_i     (rgb_tag),
		.rgb_i     (rgb),
		.pix_stb_o (pix_stb_o),
		.pix_o     (pix_o)
	);

endmodule

// ==== hdl/pix_pkg.sv ====
/* Pixel data definitions: YCbCr words, stream tags, RGB565 pairs,
   the raster output record and the colorspace coefficients. */

package pix_pkg;

	// **********************************************************
	// raster dimensions
	// **********************************************************

	localparam int x_width = 10; // up to 1024 pixel pairs per line.
	localparam int y_width = 9;  // up to 512 lines per field.

	// **********************************************************
	// payload records
	// **********************************************************

	// One 4:2:2 quadruple as it arrives on the wire, cb first.
	typedef struct packed {
		logic [7:0] cb;
		logic [7:0] y0;
		logic [7:0] cr;
		logic [7:0] y1;
	} ycc_word_t;

	typedef struct packed {
		logic field; // F bit of the start code.
		logic sol;   // first word of an active line.
	} vid_tag_t;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// Pixel 0 is the left one and sits in the upper half.
	typedef struct packed {
		rgb565_t p0;
		rgb565_t p1;
	} rgb_pair_t;

	typedef struct packed {
		logic               field;
		logic [x_width-1:0] x;
		logic [y_width-1:0] y;
		rgb_pair_t          pair;
	} pix_out_t;

	// **********************************************************
	// conversion coefficients, scaled by 256
	// **********************************************************

	localparam int coef_width = 10;

	localparam logic signed [coef_width-1:0] coef_cr_r = 10'sd359; // 1.402.
	localparam logic signed [coef_width-1:0] coef_cb_b = 10'sd454; // 1.772.
	localparam logic signed [coef_width-1:0] coef_cb_g = 10'sd88;  // 0.344.
	localparam logic signed [coef_width-1:0] coef_cr_g = 10'sd183; // 0.714.

endpackage

// ==== sim/bt656cap_model.svh ====
/* Reference model of the capture core: timing code bytes,
   YCbCr to RGB565 conversion and raster line addressing. */

`ifndef BT656CAP_MODEL_SVH
`define BT656CAP_MODEL_SVH

	// 8-bit fixed-point scalings of 1.402, 1.772, 0.344 and 0.714.
	localparam int k_cr_r = 359;
	localparam int k_cb_b = 454;
	localparam int k_cb_g = 88;
	localparam int k_cr_g = 183;

	bit model_seen  = 1'b0; // a line with pixels has been seen.
	bit model_field = 1'b0; // field of the last line with pixels.
	int model_y     = 0;

	// code byte 1 F V H P3 P2 P1 P0 with its protection bits.
	function automatic logic [7:0] code_byte(input bit f, input bit v, input bit h);
		logic [3:0] prot;
		prot = {v ^ h, f ^ h, f ^ v, f ^ v ^ h};
		return {1'b1, f, v, h, prot};
	endfunction

	// ******************************************************
	// colour conversion
	// ******************************************************

	function automatic int chroma_term(input logic [7:0] c, input int coef);
		int prod;
		prod = (int'(c) - 128) * coef;
		return prod >>> 8; // floor of the scaled product.
	endfunction

	function automatic logic [7:0] clamp_channel(input int v);
		if (v < 0)
			return 8'd0;
		if (v > 255)
			return 8'd255;
		return 8'(v);
	endfunction

	function automatic logic [15:0] pixel_565(input logic [7:0] y, input logic [7:0] cb,
		input logic [7:0] cr);
		int luma;
		logic [7:0] r8;
		logic [7:0] g8;
		logic [7:0] b8;
		luma = int'(y) - 128;
		r8 = clamp_channel(luma + chroma_term(cr, k_cr_r));
		g8 = clamp_channel(luma - chroma_term(cb, k_cb_g) - chroma_term(cr, k_cr_g));
		b8 = clamp_channel(luma + chroma_term(cb, k_cb_b));
		return {r8[7:3], g8[7:2], b8[7:3]};
	endfunction

	function automatic pix_pkg::rgb_pair_t convert_word(input pix_pkg::ycc_word_t w);
		return {pixel_565(w.y0, w.cb, w.cr), pixel_565(w.y1, w.cb, w.cr)};
	endfunction

	// line number of a new line with pixels, restarting on a field change.
	function automatic int start_line(input bit field);
		if (!model_seen || field != model_field)
			model_y = 0;
		else
			model_y = model_y + 1;
		model_seen  = 1'b1;
		model_field = field;
		return model_y;
	endfunction

`endif

// ==== sim/bt656cap_tb.sv ====
/* Testbench for the BT.656 capture core: random video stream,
   model scoreboard on every pixel pair and a watchdog. */

`timescale 1ns/1ps

module bt656cap_tb;

	localparam int clk_period_ns = 4;
	localparam int n_fields      = 6;
	localparam int margin_cycles = 64;
	localparam int pipe_latency  = 8; // from driving Y1 to pix_stb_o seen on a falling edge.

	typedef struct packed {
		pix_pkg::pix_out_t pix;
		logic [31:0]       y1_idx; // stream position of the Y1 byte.
	} expect_t;

	logic              vid_clk;
	logic              rst_n;
	logic [7:0]        vid_data = 8'h10;
	logic              pix_stb;
	pix_pkg::pix_out_t pix;

	logic [7:0]  stream_q[$];
	expect_t     exp_q[$];
	expect_t     cur;
	int unsigned cyc          = 0;
	int unsigned start_cyc    = 0;
	int unsigned n_expected   = 0;
	int unsigned n_checked    = 0;
	bit          stream_ready = 1'b0;

	`include "bt656cap_model.svh"

	tb_clk_gen u_clk_gen (.clk_o(vid_clk), .rst_n_o(rst_n));

	bt656cap_top UUT (
		.vid_clk    (vid_clk),
		.rst_n_i    (rst_n),
		.vid_data_i (vid_data),
		.pix_stb_o  (pix_stb),
		.pix_o      (pix)
	);

	always @(posedge vid_clk) cyc <= cyc + 1;

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// ******************************************************
	// stream generation
	// ******************************************************

	function automatic logic [7:0] random_byte();
		return 8'($urandom_range(254, 1)); // legal video range, never a preamble byte.
	endfunction

	function automatic logic [7:0] extreme_byte();
		return ($urandom_range(1) == 0) ? 8'h00 : 8'hff;
	endfunction

	task automatic push_filler(input int n);
		for (int i = 0; i < n; i++)
			stream_q.push_back(i[0] ? 8'h10 : 8'h80);
	endtask

	task automatic push_code(input bit f, input bit v, input bit h, input bit corrupt);
		logic [7:0] xy;
		xy = code_byte(f, v, h);
		if (corrupt)
			xy[3:0] = xy[3:0] ^ 4'($urandom_range(15, 1));
		stream_q.push_back(8'hff);
		stream_q.push_back(8'h00);
		stream_q.push_back(8'h00);
		stream_q.push_back(xy);
	endtask

	task automatic push_line(input bit f, input int n_words);
		bit                 v;
		bit                 corrupt;
		bit                 shown;
		int                 y;
		pix_pkg::ycc_word_t w;
		expect_t            e;
		v       = ($urandom_range(5) == 0);
		corrupt = ($urandom_range(7) == 0);
		shown   = !v && !corrupt; // only a clean start code outside blanking opens video.
		y       = 0;
		push_filler(4 + $urandom_range(8));
		push_code(f, v, 1'b0, corrupt);
		if (shown)
			y = start_line(f);
		for (int i = 0; i < n_words; i++) begin
			w = {random_byte(), random_byte(), random_byte(), random_byte()};
			if (shown && $urandom_range(7) == 0) begin
				w = {extreme_byte(), extreme_byte(), extreme_byte(), extreme_byte()};
				if (w.cb == 8'hff && w.y0 == 8'h00 && w.cr == 8'h00)
					w.cr = 8'hff; // an aligned FF 00 00 would read as a preamble.
			end
			stream_q.push_back(w.cb);
			stream_q.push_back(w.y0);
			stream_q.push_back(w.cr);
			stream_q.push_back(w.y1);
			if (shown) begin
				e.pix.field = f;
				e.pix.x     = i[pix_pkg::x_width-1:0];
				e.pix.y     = y[pix_pkg::y_width-1:0];
				e.pix.pair  = convert_word(w);
				e.y1_idx    = stream_q.size() - 1;
				exp_q.push_back(e);
			end
		end
		push_code(f, v, 1'b1, 1'b0);
	endtask

	task automatic build_stream();
		bit f;
		int n_lines;
		f = ($urandom_range(1) == 1);
		push_filler(16);
		for (int fld = 0; fld < n_fields; fld++) begin
			if (fld > 0 && $urandom_range(3) != 0)
				f = !f;                        // now and then a field repeats its F.
			n_lines = 3 + $urandom_range(5);
			for (int ln = 0; ln < n_lines; ln++) begin
				if ($urandom_range(3) == 0)
					push_line(f, 150 + $urandom_range(150));
				else
					push_line(f, 1 + $urandom_range(23));
			end
		end
		push_filler(32);
	endtask

	task automatic drive_stream();
		@(negedge vid_clk);
		start_cyc = cyc;
		foreach (stream_q[i]) begin
			vid_data = stream_q[i];
			@(negedge vid_clk);
		end
	endtask

	// ******************************************************
	// scoreboard, stimulus and watchdog
	// ******************************************************

	always @(negedge vid_clk) begin
		if (rst_n && pix_stb) begin
			if (exp_q.size() == 0) begin
				$display("unexpected pixel pair at column %0d, line %0d", pix.x, pix.y);
				$display("TESTBENCH FAILED");
				$fatal(1, "pixel pair without a matching word");
			end else begin
				cur = exp_q.pop_front();
				compare_value($sformatf("pair %0d rgb", n_checked), cur.pix.pair, pix.pair);
				compare_value($sformatf("pair %0d x", n_checked), cur.pix.x, pix.x);
				compare_value($sformatf("pair %0d y", n_checked), cur.pix.y, pix.y);
				compare_value($sformatf("pair %0d field", n_checked), cur.pix.field, pix.field);
				compare_value($sformatf("pair %0d latency", n_checked),
					start_cyc + cur.y1_idx + pipe_latency, cyc);
				n_checked++;
			end
		end
	end

	initial begin
		void'($urandom(32'h4329f889));
		build_stream();
		n_expected   = exp_q.size();
		stream_ready = 1'b1;
		wait (rst_n === 1'b1);
		drive_stream();
		repeat (pipe_latency + 16) @(negedge vid_clk); // the last pairs and any late extra one.
		if (n_checked == n_expected && exp_q.size() == 0) begin
			$display("%0d pixel pairs checked", n_checked);
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("checked %0d of %0d pixel pairs", n_checked, n_expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "pixel pair count differs");
		end
	end

	initial begin
		longint unsigned timeout_ns;
		wait (stream_ready);
		timeout_ns = (longint'(stream_q.size()) + margin_cycles) * clk_period_ns;
		#(timeout_ns);
		$display("timeout: %0d pixel pairs still missing", exp_q.size());
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== sim/tb_clk_gen.sv ====
/* Testbench clock and reset: 4 ns video clock, reset low for 3 cycles. */

`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int period_ns    = 4;
	localparam int reset_cycles = 3;

	initial begin
		clk_o   = 1'b0;
		rst_n_o = 1'b0;
		#(period_ns * reset_cycles);
		rst_n_o = 1'b1; // released on a falling edge.
	end

	always #(period_ns / 2) clk_o = ~clk_o;

endmodule

// ==== src.f ====
+incdir+sim
hdl/bt656_pkg.sv
hdl/pix_pkg.sv
hdl/bt656cap_decoder.sv
hdl/bt656cap_colorspace.sv
hdl/bt656cap_raster.sv
hdl/bt656cap_top.sv
sim/tb_clk_gen.sv
sim/bt656cap_tb.sv
